//--- verilog/taylor_isa_pkg.sv
`default_nettype none

package taylor_isa_pkg;

	// samples, coefficients and the accumulator share this binary point.
	localparam int FRAC_BITS = 16;

	localparam int PROG_LEN = 6;
	localparam int PC_W = $clog2(PROG_LEN);
	localparam int NUM_COEF = 4;

	typedef enum logic [1:0] {
		OP_WAIT  = 2'd0, // park until the dispatcher hands over a sample.
		OP_LOADC = 2'd1, // acc = coef.
		OP_MAC   = 2'd2, // acc = acc * x + coef.
		OP_OUT   = 2'd3  // hand acc to the result stage and go back to address 0.
	} opcode_t;

	typedef logic [1:0] coef_idx_t;
	typedef logic [PC_W-1:0] pc_t;

	typedef struct packed {
		opcode_t   opcode;
		coef_idx_t coef;
	} instr_t;

	// horner form of c3*x^3 + c2*x^2 + c1*x + c0, highest term first.
	localparam instr_t PROGRAM [PROG_LEN] = '{
		'{opcode: OP_WAIT,  coef: 2'd0},
		'{opcode: OP_LOADC, coef: 2'd3},
		'{opcode: OP_MAC,   coef: 2'd2},
		'{opcode: OP_MAC,   coef: 2'd1},
		'{opcode: OP_MAC,   coef: 2'd0},
		'{opcode: OP_OUT,   coef: 2'd0}
	};

	// sine series terms, scaled by 2**FRAC_BITS.
	localparam int COEF [NUM_COEF] = '{
		0,      // c0.
		65536,  // c1 is one.
		0,      // c2.
		-10923  // c3 is -1/6, rounded to nearest.
	};

endpackage

`default_nettype wire

//--- verilog/multicore_pkg.sv
`default_nettype none

package multicore_pkg;

	localparam int SAMPLE_W = 19; // Q2.16.
	localparam int ACC_W = 28;    // Q11.16.

	// the core field of a result is sized for this many cores.
	localparam int MAX_CORES = 32;
	localparam int CORE_IDX_W = $clog2(MAX_CORES);

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [CORE_IDX_W-1:0] core_idx_t;

	typedef struct packed {
		acc_t      value;
		core_idx_t core; // which core produced the value.
	} result_t;

endpackage

`default_nettype wire

//--- verilog/core_release.sv
`timescale 1ns/100ps
`default_nettype none

module core_release #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 14
) (
	input  wire                  clk,
	input  wire                  rst,
	output logic [NUM_CORES-1:0] core_rst
);

	localparam int GAP_W = $clog2(RELEASE_GAP + 1);
	localparam int STAGE_W = $clog2(NUM_CORES + 1);

	logic [GAP_W-1:0] gap_cnt;
	logic [STAGE_W-1:0] stage; // index of the next core to let go.
	logic gap_done;
	logic all_released;

	assign gap_done = (gap_cnt == GAP_W'(RELEASE_GAP - 1));
	assign all_released = (stage == STAGE_W'(NUM_CORES));

	always_ff @(posedge clk) begin
		if (rst) begin
			core_rst <= '1;
			gap_cnt <= '0;
			stage <= '0;
		end else if (!all_released) begin
			if (gap_done) begin
				gap_cnt <= '0;
				stage <= stage + STAGE_W'(1);
				for (int i = 0; i < NUM_CORES; i++) begin
					if (stage == STAGE_W'(i)) begin
						core_rst[i] <= 1'b0;
					end
				end
			end else begin
				gap_cnt <= gap_cnt + GAP_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/core_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_decode import taylor_isa_pkg::*; (
	input  wire       clk,
	input  wire       rst,
	input  wire       grant,
	input  wire       taken,
	output logic      idle,
	output opcode_t   exec_op,
	output coef_idx_t coef_sel,
	output logic      load_sample,
	output logic      publish
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_HOLD
	} state_t;

	state_t state;
	pc_t pc;
	instr_t instr;

	assign instr = PROGRAM[pc];
	assign coef_sel = instr.coef;

	// only ST_RUN lets an instruction reach the execute stage.
	always_comb begin
		idle = (state == ST_IDLE);
		exec_op = OP_WAIT;
		load_sample = 1'b0;
		publish = 1'b0;
		case (state)
			ST_IDLE: begin
				load_sample = grant && (instr.opcode == OP_WAIT);
			end
			ST_RUN: begin
				exec_op = instr.opcode;
				publish = (instr.opcode == OP_OUT);
			end
			default: begin
				exec_op = OP_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			pc <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load_sample) begin
						state <= ST_RUN;
						pc <= pc + pc_t'(1);
					end
				end
				ST_RUN: begin
					if (instr.opcode == OP_OUT) begin
						state <= ST_HOLD; // pc stays on OUT until the result is taken.
					end else begin
						pc <= pc + pc_t'(1);
					end
				end
				ST_HOLD: begin
					if (taken) begin
						state <= ST_IDLE;
						pc <= '0;
					end
				end
				default: begin
					state <= ST_IDLE;
					pc <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/core_execute.sv
`timescale 1ns/100ps
`default_nettype none

module core_execute import taylor_isa_pkg::*, multicore_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire opcode_t   exec_op,
	input  wire coef_idx_t coef_sel,
	input  wire            load_sample,
	input  wire sample_t   io_in,
	output acc_t           acc
);

	localparam int PROD_W = ACC_W + SAMPLE_W;

	sample_t x;
	acc_t coef;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] prod_shr;
	acc_t mac_sum;

	assign coef = acc_t'(COEF[coef_sel]);

	// full width product, then floor back to Q16 and wrap into the accumulator.
	assign prod = PROD_W'(acc) * PROD_W'(x);
	assign prod_shr = prod >>> FRAC_BITS;
	assign mac_sum = acc_t'(prod_shr) + coef;

	always_ff @(posedge clk) begin
		if (load_sample) begin
			x <= io_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else begin
			case (exec_op)
				OP_LOADC: acc <= coef;
				OP_MAC:   acc <= mac_sum;
				default:  acc <= acc; // WAIT and OUT leave it alone.
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/core_result.sv
`timescale 1ns/100ps
`default_nettype none

module core_result import multicore_pkg::*; (
	input  wire       clk,
	input  wire       rst,
	input  wire       publish,
	input  wire       taken,
	input  wire acc_t acc,
	output logic      done,
	output acc_t      value
);

	// done stays up for as long as the output selector leaves us waiting.
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else if (publish) begin
			done <= 1'b1;
		end else if (taken) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (publish) begin
			value <= acc;
		end
	end

endmodule

`default_nettype wire

//--- verilog/taylor_core.sv
`timescale 1ns/100ps
`default_nettype none

module taylor_core import taylor_isa_pkg::*, multicore_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          grant,
	input  wire          taken,
	input  wire sample_t io_in,
	output logic         idle,
	output logic         done,
	output acc_t         value
);

	opcode_t exec_op;
	coef_idx_t coef_sel;
	logic load_sample;
	logic publish;
	acc_t acc;

	core_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.grant       (grant),
		.taken       (taken),
		.idle        (idle),
		.exec_op     (exec_op),
		.coef_sel    (coef_sel),
		.load_sample (load_sample),
		.publish     (publish)
	);

	core_execute u_execute (
		.clk         (clk),
		.rst         (rst),
		.exec_op     (exec_op),
		.coef_sel    (coef_sel),
		.load_sample (load_sample),
		.io_in       (io_in),
		.acc         (acc)
	);

	core_result u_result (
		.clk     (clk),
		.rst     (rst),
		.publish (publish),
		.taken   (taken),
		.acc     (acc),
		.done    (done),
		.value   (value)
	);

endmodule

`default_nettype wire

//--- verilog/multicore.sv
`timescale 1ns/100ps
`default_nettype none

module multicore import multicore_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 14
) (
	input  wire          clk,
	input  wire          rst,
	input  wire          in_valid,
	input  wire sample_t io_in,
	output logic         in_ready,
	output logic         res_valid,
	output result_t      res
);

	logic [NUM_CORES-1:0] core_rst;
	logic [NUM_CORES-1:0] core_reset;
	logic [NUM_CORES-1:0] idle;
	logic [NUM_CORES-1:0] avail;
	logic [NUM_CORES-1:0] done;
	logic [NUM_CORES-1:0] grant;
	logic [NUM_CORES-1:0] taken;
	acc_t value [NUM_CORES];
	core_idx_t sel_idx;
	acc_t sel_value;

	// isolates the lowest set bit, so core 0 always has priority.
	function automatic logic [NUM_CORES-1:0] lowest_set(input logic [NUM_CORES-1:0] req);
		return req & (~req + NUM_CORES'(1));
	endfunction

	if (NUM_CORES > MAX_CORES) begin : g_size_check
		$error("NUM_CORES is larger than the core field of result_t can tag");
	end

	core_release #(
		.NUM_CORES   (NUM_CORES),
		.RELEASE_GAP (RELEASE_GAP)
	) u_release (
		.clk      (clk),
		.rst      (rst),
		.core_rst (core_rst)
	);

	assign core_reset = core_rst | {NUM_CORES{rst}};

	// a core still held in reset is never offered work.
	assign avail = idle & ~core_rst;
	assign in_ready = |avail;
	assign grant = (in_valid && in_ready) ? lowest_set(avail) : '0;

	// taken must follow done in the same cycle, or a waiting core would be picked twice.
	assign taken = lowest_set(done);

	always_comb begin
		sel_idx = '0;
		sel_value = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (done[i]) begin
				sel_idx = core_idx_t'(i);
				sel_value = value[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= |done;
		end
	end

	always_ff @(posedge clk) begin
		if (|done) begin
			res.value <= sel_value;
			res.core <= sel_idx;
		end
	end

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		taylor_core u_core (
			.clk   (clk),
			.rst   (core_reset[i]),
			.grant (grant[i]),
			.taken (taken[i]),
			.io_in (io_in),
			.idle  (idle[i]),
			.done  (done[i]),
			.value (value[i])
		);
	end

endmodule

`default_nettype wire

//--- tb/multicore_checker.sv
`timescale 1ns/100ps
`default_nettype none

module multicore_checker import multicore_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 14
) (
	input wire          clk,
	input wire          rst,
	input wire          in_valid,
	input wire sample_t io_in,
	input wire          in_ready,
	input wire          res_valid,
	input wire result_t res
);

	// sine series in Q16, c0 first.
	localparam longint C0 = 0;
	localparam longint C1 = 65536;
	localparam longint C2 = 0;
	localparam longint C3 = -10923;

	int value_errs = 0;
	int tag_errs = 0;
	int proto_errs = 0;
	int outstanding = 0;

	logic [NUM_CORES-1:0] busy;
	logic [NUM_CORES-1:0] released;
	logic [NUM_CORES-1:0] free;
	acc_t expect_val [NUM_CORES];
	int rel_cnt;
	int k;
	int c;

	function automatic longint wrap28(input longint v);
		return (v <<< 36) >>> 36;
	endfunction

	function automatic acc_t horner(input sample_t x);
		longint a;
		longint cs [3];
		cs = '{C2, C1, C0};
		a = C3;
		for (int i = 0; i < 3; i++) begin
			a = wrap28(((a * longint'(x)) >>> 16) + cs[i]); // floor shift, then wrap.
		end
		return acc_t'(a);
	endfunction

	function automatic int lowest_free(input logic [NUM_CORES-1:0] f);
		for (int i = 0; i < NUM_CORES; i++) begin
			if (f[i]) return i;
		end
		return -1;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			busy = '0;
			outstanding = 0;
			rel_cnt = 0;
		end else begin
			for (int i = 0; i < NUM_CORES; i++) begin
				released[i] = (rel_cnt >= RELEASE_GAP * (i + 1));
			end
			if (rel_cnt < RELEASE_GAP && res_valid) begin
				$display("%0t: res_valid high before core 0 left reset", $time);
				proto_errs++;
			end
			// a core is free again in the cycle its result shows up.
			if (res_valid) begin
				c = int'(res.core);
				if (c >= NUM_CORES) begin
					$display("%0t: result tagged with core %0d, which does not exist", $time, c);
					tag_errs++;
				end else if (!busy[c]) begin
					$display("%0t: unexpected result from core %0d with no pending sample",
						$time, c);
					tag_errs++;
				end else begin
					if (res.value !== expect_val[c]) begin
						$display("FAIL %0t res.value expected %0d actual %0d",
							$time, expect_val[c], res.value);
						value_errs++;
					end
					busy[c] = 1'b0;
					outstanding--;
				end
			end
			free = ~busy & released;
			if (in_ready !== (|free)) begin
				$display("FAIL %0t in_ready expected %0b actual %0b", $time, |free, in_ready);
				proto_errs++;
			end
			if (in_valid && in_ready) begin
				k = lowest_free(free);
				if (k < 0) begin
					$display("%0t: sample accepted while every modeled core is busy", $time);
					proto_errs++;
				end else begin
					busy[k] = 1'b1;
					expect_val[k] = horner(io_in);
					outstanding++;
				end
			end
			if (rel_cnt <= NUM_CORES * RELEASE_GAP) rel_cnt++;
		end
	end

endmodule

`default_nettype wire

//--- tb/multicore_sva.sv
`timescale 1ns/100ps
`default_nettype none

module multicore_sva import multicore_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 14
) (
	input wire                 clk,
	input wire                 rst,
	input wire                 in_valid,
	input wire                 in_ready,
	input wire                 res_valid,
	input wire result_t        res,
	input wire [NUM_CORES-1:0] idle
);

	int since_rst;

	always @(posedge clk) begin
		if (rst) since_rst <= 0;
		else if (since_rst < RELEASE_GAP) since_rst <= since_rst + 1;
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		since_rst < RELEASE_GAP |-> !in_ready && !res_valid)
		else $error("in_ready or res_valid high while core 0 is still in reset");

	// a core cannot finish twice in a row, so back-to-back results come from different cores.
	a_res_single: assert property (@(posedge clk) disable iff (rst)
		res_valid && $past(res_valid) |-> res.core != $past(res.core))
		else $error("one result delivered on two cycles in a row");

	a_no_start_unready: assert property (@(posedge clk) disable iff (rst)
		!(in_valid && in_ready) |=> ($past(idle) & ~idle) == '0)
		else $error("a core started work without an accepted sample");

	a_start_on_accept: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready |=> $onehot($past(idle) & ~idle))
		else $error("an accepted sample did not start exactly one core");

endmodule

bind multicore multicore_sva #(
	.NUM_CORES   (NUM_CORES),
	.RELEASE_GAP (RELEASE_GAP)
) u_sva (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.res_valid (res_valid),
	.res       (res),
	.idle      (idle)
);

`default_nettype wire

//--- tb/tb_multicore.sv
`timescale 1ns/100ps
`default_nettype none

module tb_multicore import multicore_pkg::*; ();

	localparam int NUM_CORES = 4;
	localparam int RELEASE_GAP = 14;

	logic clk;
	logic rst;
	logic in_valid;
	sample_t io_in;
	logic in_ready;
	logic res_valid;
	result_t res;

	sample_t samples[$];
	int gaps[$];
	int limit;
	int cycles;
	bit opened;

	multicore #(
		.NUM_CORES   (NUM_CORES),
		.RELEASE_GAP (RELEASE_GAP)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.io_in     (io_in),
		.in_ready  (in_ready),
		.res_valid (res_valid),
		.res       (res)
	);

	multicore_checker #(
		.NUM_CORES   (NUM_CORES),
		.RELEASE_GAP (RELEASE_GAP)
	) u_checker (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.io_in     (io_in),
		.in_ready  (in_ready),
		.res_valid (res_valid),
		.res       (res)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// each line of the data file is a sample in hex and an idle gap in cycles.
	task automatic read_tests(output bit ok);
		int fd;
		int n;
		string line;
		logic [31:0] raw;
		int gap;
		ok = 1'b0;
		fd = $fopen("tb/multicore_tests.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %d", raw, gap);
					if (n == 2) begin
						samples.push_back(sample_t'(raw));
						gaps.push_back(gap);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// holds the sample on the bus until a rising edge sees in_ready.
	task automatic send_sample(input sample_t s);
		logic accepted;
		in_valid = 1'b1;
		io_in = s;
		do begin
			accepted = in_ready; // in_ready only moves on the rising edge.
			@(negedge clk);
		end while (!accepted);
		in_valid = 1'b0;
	endtask

	task automatic report_counts();
		$display("errors: %0d value, %0d tag, %0d protocol",
			u_checker.value_errs, u_checker.tag_errs, u_checker.proto_errs);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles with %0d results outstanding",
				cycles, u_checker.outstanding);
			report_counts();
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		io_in = '0;
		cycles = 0;
		limit = 0;
		read_tests(opened);
		if (!opened) begin
			$display("cannot open tb/multicore_tests.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			limit = NUM_CORES * RELEASE_GAP + 10 * samples.size() + 50;
			foreach (gaps[i]) begin
				limit = limit + gaps[i];
			end
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			foreach (samples[i]) begin
				send_sample(samples[i]);
				repeat (gaps[i]) @(negedge clk);
			end
			while (u_checker.outstanding != 0) begin
				@(negedge clk);
			end
			repeat (3) @(negedge clk); // room for a stray result to show up.
			report_counts();
			if (u_checker.value_errs + u_checker.tag_errs + u_checker.proto_errs == 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb/multicore_tests.txt
# sample: 19-bit Q2.16 in hex, two's complement
# gap: idle cycles after the sample is accepted
00000 0
10000 3
70000 0
08000 60
38000 0
48000 0
3ffff 0
40000 20
1a2b3 0
5c0de 0
0c350 2
7ffff 0
01000 30
64000 0

//--- vlog.f
verilog/taylor_isa_pkg.sv
verilog/multicore_pkg.sv
verilog/core_release.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_result.sv
verilog/taylor_core.sv
verilog/multicore.sv
tb/multicore_checker.sv
tb/multicore_sva.sv
tb/tb_multicore.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the multicore testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f run.log
verilator --binary --timing --assert --top-module tb_multicore -f vlog.f \
	&& ./obj_dir/Vtb_multicore > run.log 2>&1
cat run.log 2>/dev/null
grep -q "TEST PASS" run.log && exit 0 || exit 1
